//--- design/intc_pkg.sv
`default_nettype none

package intc_pkg;

// bus and field widths
localparam int DATA_W = 32;
localparam int ADDR_W = 8;
localparam int PRIO_W = 3;
localparam int ID_W   = 4;

// word addresses, not byte addresses
// source k sits at SRC_BASE + k, id 0 is never used
localparam logic [ADDR_W-1:0] SRC_BASE         = 8'h00;
localparam logic [ADDR_W-1:0] THRESHOLD_ADDR   = 8'h20;
localparam logic [ADDR_W-1:0] CLAIM_ADDR       = 8'h21;
localparam logic [ADDR_W-1:0] MSIP_ADDR        = 8'h30;
localparam logic [ADDR_W-1:0] MTIMECMP_LO_ADDR = 8'h31;
localparam logic [ADDR_W-1:0] MTIMECMP_HI_ADDR = 8'h32;
localparam logic [ADDR_W-1:0] MTIME_LO_ADDR    = 8'h33;
localparam logic [ADDR_W-1:0] MTIME_HI_ADDR    = 8'h34;

// source word layout
// priority sits in the low bits
localparam int EN_BIT   = 8;
localparam int PEND_BIT = 16;

// per-source view handed to the resolver
typedef struct packed {
    logic              pending;
    logic              enable;
    logic [PRIO_W-1:0] prio;
} src_state_t;

endpackage

`default_nettype wire

//--- design/intc_reg_op_if.sv
`timescale 1ns/1ps
`default_nettype none

// one register operation per bus access, valid during the ack cycle
interface intc_reg_op_if import intc_pkg::*; ();

logic              op_valid;
// claim read, op_wdata holds the claimed id
logic              op_claim;
logic [ADDR_W-1:0] op_addr;
logic [DATA_W-1:0] op_wdata;

modport host (
    output op_valid,
    output op_claim,
    output op_addr,
    output op_wdata
);

modport unit (
    input  op_valid,
    input  op_claim,
    input  op_addr,
    input  op_wdata
);

endinterface

`default_nettype wire

//--- design/intc_wb_front.sv
`timescale 1ns/1ps
`default_nettype none

module intc_wb_front import intc_pkg::*; #(
    parameter int N_SRC = 8
) (
    input  logic                clk,
    input  logic                arst_n,

    // wishbone classic slave
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [ADDR_W-1:0]   wb_adr,
    input  logic [DATA_W-1:0]   wb_dat_w,
    output logic [DATA_W-1:0]   wb_dat_r,
    output logic                wb_ack,

    intc_reg_op_if.host         op,

    // read words from the register-holding units
    input  logic [DATA_W-1:0]   src_rdata [N_SRC],
    input  logic [DATA_W-1:0]   timer_rdata,
    input  logic [ID_W-1:0]     best_id,
    output logic [PRIO_W-1:0]   threshold
);

logic              req;
logic              claim_req;
logic [DATA_W-1:0] rd_word;

// new access, never taken again while ack is up
assign req       = wb_cyc & wb_stb & ~wb_ack;
assign claim_req = req & ~wb_we & (wb_adr == CLAIM_ADDR);

// all units return zero unless addressed, so OR them together
always_comb begin
    rd_word = timer_rdata;
    for (int i = 0; i < N_SRC; i++) begin
        rd_word = rd_word | src_rdata[i];
    end
    if (wb_adr == THRESHOLD_ADDR) begin
        rd_word = rd_word | DATA_W'(threshold);
    end
    if (wb_adr == CLAIM_ADDR) begin
        rd_word = rd_word | DATA_W'(best_id);
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        wb_ack      <= 1'b0;
        op.op_valid <= 1'b0;
        op.op_claim <= 1'b0;
    end
    else begin
        wb_ack      <= req;
        op.op_valid <= (req & wb_we) | claim_req;
        op.op_claim <= claim_req;
    end
end

// operation payload and read data for the ack cycle
always_ff @(posedge clk) begin
    if (req) begin
        op.op_addr  <= wb_adr;
        op.op_wdata <= claim_req ? DATA_W'(best_id) : wb_dat_w;
        wb_dat_r    <= wb_we ? '0 : rd_word;
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        threshold <= '0;
    end
    else if (op.op_valid && !op.op_claim && op.op_addr == THRESHOLD_ADDR) begin
        threshold <= op.op_wdata[PRIO_W-1:0];
    end
end

endmodule

`default_nettype wire

//--- design/intc_gateway.sv
`timescale 1ns/1ps
`default_nettype none

module intc_gateway import intc_pkg::*; #(
    parameter int SRC_ID = 1
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                irq,

    intc_reg_op_if.unit         op,

    input  logic [ADDR_W-1:0]   rd_addr,
    output logic [DATA_W-1:0]   rdata,
    output src_state_t          state
);

localparam logic [ADDR_W-1:0] MY_ADDR = ADDR_W'(SRC_BASE + SRC_ID);

logic              irq_q;
logic              irq_d;
logic              irq_rise;
logic              claim_hit;
logic              reg_wr;
logic              pending;
logic              enable;
logic [PRIO_W-1:0] prio;

assign irq_rise  = irq_q & ~irq_d;
assign claim_hit = op.op_valid & op.op_claim &
                   (op.op_wdata[ID_W-1:0] == ID_W'(SRC_ID));
assign reg_wr    = op.op_valid & ~op.op_claim & (op.op_addr == MY_ADDR);

// input sampling and edge detect
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        irq_q <= 1'b0;
        irq_d <= 1'b0;
    end
    else begin
        irq_q <= irq;
        irq_d <= irq_q;
    end
end

// a new edge beats a claim in the same cycle
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        pending <= 1'b0;
    end
    else if (irq_rise) begin
        pending <= 1'b1;
    end
    else if (claim_hit) begin
        pending <= 1'b0;
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        enable <= 1'b0;
        prio   <= '0;
    end
    else if (reg_wr) begin
        enable <= op.op_wdata[EN_BIT];
        prio   <= op.op_wdata[PRIO_W-1:0];
    end
end

always_comb begin
    rdata = '0;
    if (rd_addr == MY_ADDR) begin
        rdata[PRIO_W-1:0] = prio;
        rdata[EN_BIT]     = enable;
        rdata[PEND_BIT]   = pending;
    end
end

assign state.pending = pending;
assign state.enable  = enable;
assign state.prio    = prio;

endmodule

`default_nettype wire

//--- design/intc_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module intc_resolver import intc_pkg::*; #(
    parameter int N_SRC = 8
) (
    input  logic                clk,
    input  logic                arst_n,

    // entry i belongs to source id i+1
    input  src_state_t          state [N_SRC],
    input  logic [PRIO_W-1:0]   threshold,

    output logic [ID_W-1:0]     best_id,
    output logic                meip
);

logic [ID_W-1:0]   win_id;
logic [PRIO_W-1:0] win_prio;

// strict compare in id order keeps the lowest id on a tie
// and never picks priority 0
always_comb begin
    win_id   = '0;
    win_prio = '0;
    for (int i = 0; i < N_SRC; i++) begin
        if (state[i].pending && state[i].enable && state[i].prio > win_prio) begin
            win_prio = state[i].prio;
            win_id   = ID_W'(i + 1);
        end
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        best_id <= '0;
        meip    <= 1'b0;
    end
    else begin
        best_id <= win_id;
        // no candidate leaves win_prio at 0, never above threshold
        meip    <= (win_prio > threshold);
    end
end

endmodule

`default_nettype wire

//--- design/intc_mtimer.sv
`timescale 1ns/1ps
`default_nettype none

module intc_mtimer import intc_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,

    intc_reg_op_if.unit         op,

    input  logic [ADDR_W-1:0]   rd_addr,
    output logic [DATA_W-1:0]   rdata,
    output logic                msip,
    output logic                mtip
);

logic [2*DATA_W-1:0] mtime;
logic [2*DATA_W-1:0] mtimecmp;
logic                reg_wr;

assign reg_wr = op.op_valid & ~op.op_claim;

// free-running system time
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        mtime <= '0;
    end
    else begin
        mtime <= mtime + 1'b1;
    end
end

// halves written separately, all ones keeps mtip low
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        mtimecmp <= '1;
    end
    else if (reg_wr) begin
        if (op.op_addr == MTIMECMP_LO_ADDR) begin
            mtimecmp[DATA_W-1:0] <= op.op_wdata;
        end
        if (op.op_addr == MTIMECMP_HI_ADDR) begin
            mtimecmp[2*DATA_W-1:DATA_W] <= op.op_wdata;
        end
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        msip <= 1'b0;
    end
    else if (reg_wr && op.op_addr == MSIP_ADDR) begin
        msip <= op.op_wdata[0];
    end
end

// one cycle behind the compare
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        mtip <= 1'b0;
    end
    else begin
        mtip <= (mtime >= mtimecmp);
    end
end

always_comb begin
    case (rd_addr)
        MSIP_ADDR:        rdata = DATA_W'(msip);
        MTIMECMP_LO_ADDR: rdata = mtimecmp[DATA_W-1:0];
        MTIMECMP_HI_ADDR: rdata = mtimecmp[2*DATA_W-1:DATA_W];
        MTIME_LO_ADDR:    rdata = mtime[DATA_W-1:0];
        MTIME_HI_ADDR:    rdata = mtime[2*DATA_W-1:DATA_W];
        default:          rdata = '0;
    endcase
end

endmodule

`default_nettype wire

//--- design/intc_top.sv
`timescale 1ns/1ps
`default_nettype none

module intc_top import intc_pkg::*; #(
    parameter int N_SRC = 8
) (
    input  logic                clk,
    input  logic                arst_n,

    // wishbone classic slave
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [ADDR_W-1:0]   wb_adr,
    input  logic [DATA_W-1:0]   wb_dat_w,
    output logic [DATA_W-1:0]   wb_dat_r,
    output logic                wb_ack,

    // edge-triggered interrupt lines, bit k is source id k+1
    input  logic [N_SRC-1:0]    irq_src,

    // to the core
    output logic                msip,
    output logic                mtip,
    output logic                meip
);

logic [DATA_W-1:0] src_rdata [N_SRC];
src_state_t        src_state [N_SRC];
logic [DATA_W-1:0] timer_rdata;
logic [ID_W-1:0]   best_id;
logic [PRIO_W-1:0] threshold;

intc_reg_op_if reg_op ();

intc_wb_front #(
    .N_SRC       ( N_SRC       )
) u_wb_front (
    .clk         ( clk         ),
    .arst_n      ( arst_n      ),
    .wb_cyc      ( wb_cyc      ),
    .wb_stb      ( wb_stb      ),
    .wb_we       ( wb_we       ),
    .wb_adr      ( wb_adr      ),
    .wb_dat_w    ( wb_dat_w    ),
    .wb_dat_r    ( wb_dat_r    ),
    .wb_ack      ( wb_ack      ),
    .op          ( reg_op.host ),
    .src_rdata   ( src_rdata   ),
    .timer_rdata ( timer_rdata ),
    .best_id     ( best_id     ),
    .threshold   ( threshold   )
);

for (genvar k = 0; k < N_SRC; k++) begin : g_src
    intc_gateway #(
        .SRC_ID  ( k + 1          )
    ) u_gateway (
        .clk     ( clk            ),
        .arst_n  ( arst_n         ),
        .irq     ( irq_src[k]     ),
        .op      ( reg_op.unit    ),
        .rd_addr ( wb_adr         ),
        .rdata   ( src_rdata[k]   ),
        .state   ( src_state[k]   )
    );
end

intc_resolver #(
    .N_SRC     ( N_SRC     )
) u_resolver (
    .clk       ( clk       ),
    .arst_n    ( arst_n    ),
    .state     ( src_state ),
    .threshold ( threshold ),
    .best_id   ( best_id   ),
    .meip      ( meip      )
);

intc_mtimer u_mtimer (
    .clk     ( clk         ),
    .arst_n  ( arst_n      ),
    .op      ( reg_op.unit ),
    .rd_addr ( wb_adr      ),
    .rdata   ( timer_rdata ),
    .msip    ( msip        ),
    .mtip    ( mtip        )
);

endmodule

`default_nettype wire

//--- tests/intc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module intc_tb import intc_pkg::*; ();

localparam int N_SRC   = 8;
localparam int TIMEOUT = 50;

logic              clk;
logic              arst_n;
logic              wb_cyc;
logic              wb_stb;
logic              wb_we;
logic [ADDR_W-1:0] wb_adr;
logic [DATA_W-1:0] wb_dat_w;
logic [DATA_W-1:0] wb_dat_r;
logic              wb_ack;
logic [N_SRC-1:0]  irq_src;
logic              msip;
logic              mtip;
logic              meip;

logic [31:0]       lfsr_state;
int                errors;
int                tests_passed;
int                tests_failed;

// reference model of the source registers, index is the source id
logic [PRIO_W-1:0] prio_m [1:N_SRC];
logic              en_m   [1:N_SRC];
logic              pend_m [1:N_SRC];

intc_top #(
    .N_SRC    ( N_SRC    )
) UUT (
    .clk      ( clk      ),
    .arst_n   ( arst_n   ),
    .wb_cyc   ( wb_cyc   ),
    .wb_stb   ( wb_stb   ),
    .wb_we    ( wb_we    ),
    .wb_adr   ( wb_adr   ),
    .wb_dat_w ( wb_dat_w ),
    .wb_dat_r ( wb_dat_r ),
    .wb_ack   ( wb_ack   ),
    .irq_src  ( irq_src  ),
    .msip     ( msip     ),
    .mtip     ( mtip     ),
    .meip     ( meip     )
);

always #4 clk = ~clk;

// x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v = {v[30:0], fb};
    end
    return v;
endfunction

// source word as the register map lays it out
function automatic logic [31:0] src_word(input logic pend, input logic en,
                                         input logic [PRIO_W-1:0] prio);
    return (32'(pend) << PEND_BIT) | (32'(en) << EN_BIT) | 32'(prio);
endfunction

// highest priority first, lowest id among equals
function automatic int expected_claim();
    for (int p = (1 << PRIO_W) - 1; p > 0; p--) begin
        for (int k = 1; k <= N_SRC; k++) begin
            if (pend_m[k] && en_m[k] && int'(prio_m[k]) == p) begin
                return k;
            end
        end
    end
    return 0;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        $display("** Error: %s expected %h, got %h", name, expected, actual);
        errors++;
    end
endtask

task automatic wb_access(input logic we, input logic [ADDR_W-1:0] adr,
                         input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    bit got;
    n = 0;
    got = 0;
    rdata = '0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    while (!got && n < TIMEOUT) begin
        @(negedge clk);
        if (wb_ack) begin
            got = 1;
            rdata = wb_dat_r;
        end
        n++;
    end
    if (!got) begin
        $display("bus access to word %h never got an ack", adr);
        errors++;
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
endtask

task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [31:0] data);
    logic [31:0] unused_rd;
    wb_access(1'b1, adr, data, unused_rd);
endtask

task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, '0, data);
endtask

task automatic pulse_irq(input logic [N_SRC-1:0] mask);
    @(posedge clk);
    irq_src <= mask;
    repeat (2) @(posedge clk);
    irq_src <= '0;
    for (int k = 1; k <= N_SRC; k++) begin
        if (mask[k-1]) begin
            pend_m[k] = 1'b1;
        end
    end
endtask

task automatic wait_for(input bit use_mtip, input logic level, input int limit,
                        input string what);
    int n;
    bit seen;
    n = 0;
    seen = 0;
    while (!seen && n < limit) begin
        @(negedge clk);
        seen = ((use_mtip ? mtip : meip) == level);
        n++;
    end
    if (!seen) begin
        $display("timed out after %0d cycles waiting for %s", limit, what);
        errors++;
    end
endtask

// meip must stay low for the whole window
task automatic expect_meip_quiet(input int cycles);
    bit rose;
    rose = 0;
    for (int n = 0; n < cycles; n++) begin
        @(negedge clk);
        if (meip) begin
            rose = 1;
        end
    end
    if (rose) begin
        $display("meip went high while the source was masked");
        errors++;
    end
endtask

task automatic end_test(input string name, input int err_at_start);
    if (errors == err_at_start) begin
        tests_passed++;
        $display("%s: ok", name);
    end
    else begin
        tests_failed++;
        $display("%s: %0d errors", name, errors - err_at_start);
    end
endtask

task automatic test_reset();
    int          e0;
    logic [31:0] rd;
    logic [31:0] t0;
    e0 = errors;
    for (int k = 1; k <= N_SRC; k++) begin
        wb_read(SRC_BASE + ADDR_W'(k), rd);
        check_value($sformatf("src%0d word", k), 32'h0, rd);
    end
    wb_read(THRESHOLD_ADDR, rd);
    check_value("threshold", 32'h0, rd);
    wb_read(CLAIM_ADDR, rd);
    check_value("claim", 32'h0, rd);
    @(negedge clk);
    check_value("msip", 32'h0, 32'(msip));
    check_value("mtip", 32'h0, 32'(mtip));
    check_value("meip", 32'h0, 32'(meip));
    wb_read(MTIME_LO_ADDR, t0);
    wb_read(MTIME_LO_ADDR, rd);
    if (t0 == 0) begin
        $display("** Error: mtime_lo expected nonzero, got %h", t0);
        errors++;
    end
    if (rd <= t0) begin
        $display("** Error: mtime_lo expected above %h, got %h", t0, rd);
        errors++;
    end
    end_test("reset_state", e0);
endtask

task automatic test_readback();
    int          e0;
    logic [31:0] r;
    logic [31:0] rd;
    logic [31:0] thr;
    logic [31:0] cmp_lo;
    logic [31:0] cmp_hi;
    e0 = errors;
    for (int k = 1; k <= N_SRC; k++) begin
        r = lfsr_bits(PRIO_W);
        prio_m[k] = r[PRIO_W-1:0];
        r = lfsr_bits(1);
        en_m[k] = r[0];
        // pending bit set in the write data must not stick
        wb_write(SRC_BASE + ADDR_W'(k), src_word(1'b1, en_m[k], prio_m[k]));
    end
    thr = lfsr_bits(PRIO_W);
    wb_write(THRESHOLD_ADDR, thr);
    cmp_lo = lfsr_bits(32);
    cmp_hi = lfsr_bits(32);
    if (cmp_hi == 0) begin
        cmp_hi = 32'h1;
    end
    wb_write(MTIMECMP_LO_ADDR, cmp_lo);
    wb_write(MTIMECMP_HI_ADDR, cmp_hi);
    for (int k = 1; k <= N_SRC; k++) begin
        wb_read(SRC_BASE + ADDR_W'(k), rd);
        check_value($sformatf("src%0d word", k), src_word(1'b0, en_m[k], prio_m[k]), rd);
    end
    wb_read(THRESHOLD_ADDR, rd);
    check_value("threshold", thr, rd);
    wb_read(MTIMECMP_LO_ADDR, rd);
    check_value("mtimecmp_lo", cmp_lo, rd);
    wb_read(MTIMECMP_HI_ADDR, rd);
    check_value("mtimecmp_hi", cmp_hi, rd);
    end_test("register_readback", e0);
endtask

task automatic test_priority_claim();
    int               e0;
    int               exp_id;
    logic [31:0]      r;
    logic [31:0]      rd;
    logic [N_SRC-1:0] mask;
    e0 = errors;
    wb_write(THRESHOLD_ADDR, 32'h0);
    for (int k = 1; k <= N_SRC; k++) begin
        r = lfsr_bits(PRIO_W);
        prio_m[k] = r[PRIO_W-1:0];
        // at least one candidate so meip has to rise
        if (k == 1 && prio_m[k] == 0) begin
            prio_m[k] = 1;
        end
        en_m[k] = 1'b1;
        wb_write(SRC_BASE + ADDR_W'(k), src_word(1'b0, 1'b1, prio_m[k]));
    end
    r = lfsr_bits(N_SRC);
    mask = r[N_SRC-1:0] | N_SRC'(1);
    pulse_irq(mask);
    wait_for(1'b0, 1'b1, TIMEOUT, "meip high");
    for (int n = 0; n <= N_SRC; n++) begin
        exp_id = expected_claim();
        wb_read(CLAIM_ADDR, rd);
        check_value("claim", 32'(exp_id), rd);
        if (exp_id == 0) begin
            break;
        end
        pend_m[exp_id] = 1'b0;
        wb_read(SRC_BASE + ADDR_W'(exp_id), rd);
        check_value($sformatf("src%0d pending", exp_id), 32'h0, 32'(rd[PEND_BIT]));
    end
    wait_for(1'b0, 1'b0, TIMEOUT, "meip low");
    end_test("priority_claim", e0);
endtask

task automatic test_masking();
    int          e0;
    int          dis_id;
    logic [31:0] rd;
    e0 = errors;
    for (int k = 1; k <= N_SRC; k++) begin
        en_m[k] = 1'b0;
        prio_m[k] = '0;
        wb_write(SRC_BASE + ADDR_W'(k), 32'h0);
    end
    // priority equal to threshold is not above it
    prio_m[1] = 3;
    en_m[1] = 1'b1;
    wb_write(SRC_BASE + ADDR_W'(1), src_word(1'b0, 1'b1, prio_m[1]));
    wb_write(THRESHOLD_ADDR, 32'h3);
    pulse_irq(N_SRC'(1));
    wb_read(SRC_BASE + ADDR_W'(1), rd);
    check_value("src1 word", src_word(1'b1, 1'b1, prio_m[1]), rd);
    expect_meip_quiet(12);
    wb_read(CLAIM_ADDR, rd);
    check_value("claim", 32'(expected_claim()), rd);
    pend_m[1] = 1'b0;
    wb_read(SRC_BASE + ADDR_W'(1), rd);
    check_value("src1 word", src_word(1'b0, 1'b1, prio_m[1]), rd);

    dis_id = N_SRC;
    en_m[dis_id] = 1'b0;
    prio_m[dis_id] = 7;
    wb_write(SRC_BASE + ADDR_W'(dis_id), src_word(1'b0, 1'b0, prio_m[dis_id]));
    wb_write(THRESHOLD_ADDR, 32'h0);
    pulse_irq(N_SRC'(1) << (dis_id - 1));
    wb_read(SRC_BASE + ADDR_W'(dis_id), rd);
    check_value($sformatf("src%0d word", dis_id), src_word(1'b1, 1'b0, prio_m[dis_id]), rd);
    expect_meip_quiet(12);
    wb_read(CLAIM_ADDR, rd);
    check_value("claim", 32'(expected_claim()), rd);
    end_test("threshold_enable_mask", e0);
endtask

task automatic test_timer();
    int          e0;
    logic [31:0] rd;
    logic [31:0] lo;
    logic [31:0] hi;
    logic [63:0] cmp;
    e0 = errors;
    wb_write(MSIP_ADDR, 32'h1);
    @(negedge clk);
    check_value("msip", 32'h1, 32'(msip));
    wb_read(MSIP_ADDR, rd);
    check_value("msip word", 32'h1, rd);
    wb_write(MSIP_ADDR, 32'h0);
    @(negedge clk);
    check_value("msip", 32'h0, 32'(msip));

    wb_read(MTIME_LO_ADDR, lo);
    wb_read(MTIME_HI_ADDR, hi);
    cmp = {hi, lo} + 64'd40;
    wb_write(MTIMECMP_LO_ADDR, cmp[31:0]);
    wb_write(MTIMECMP_HI_ADDR, cmp[63:32]);
    @(negedge clk);
    check_value("mtip", 32'h0, 32'(mtip));
    wait_for(1'b1, 1'b1, 100, "mtip high");
    wb_write(MTIMECMP_LO_ADDR, 32'hffff_ffff);
    wb_write(MTIMECMP_HI_ADDR, 32'hffff_ffff);
    wait_for(1'b1, 1'b0, TIMEOUT, "mtip low");
    end_test("timer_software_irq", e0);
endtask

initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    irq_src      = '0;
    lfsr_state   = 32'd94948;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int k = 1; k <= N_SRC; k++) begin
        prio_m[k] = '0;
        en_m[k]   = 1'b0;
        pend_m[k] = 1'b0;
    end
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    test_reset();
    test_readback();
    test_priority_claim();
    test_masking();
    test_timer();

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (errors == 0) begin
        $display("Verification passed");
    end
    else begin
        $display("Verification failed");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- files.f
design/intc_pkg.sv
design/intc_reg_op_if.sv
design/intc_wb_front.sv
design/intc_gateway.sv
design/intc_resolver.sv
design/intc_mtimer.sv
design/intc_top.sv
tests/intc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the interrupt controller testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module intc_tb -f files.f -o intc_sim

./obj_dir/intc_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
